/* list.f */
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_axi_master.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/axi_mem_model.sv
testbench/dcache_sva.sv
testbench/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_tag_store.sv
  - hdl/dcache_data_store.sv
  - hdl/dcache_axi_master.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/dcache_sva.sv
      - testbench/tb_dcache.sv

/* testbench/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int INDEX_W        = 4;
    localparam int MEM_WORDS      = 4096;
    localparam int MEM_IDX_W      = $clog2(MEM_WORDS);
    localparam int DRV_NS         = 2;
    // 8 misses of up to 90 cycles each plus hits and reset leave a wide margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [ADDR_W-1:0] COLD_ADDR  = 32'h0000_1044;  // set 2
    localparam logic [ADDR_W-1:0] ALLOC_LINE = 32'h0000_2180;  // set 12

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    cpu_req_t  req;
    logic      req_ready;
    word_t     rdata;
    axi_addr_t ar;
    logic      ar_valid;
    logic      ar_ready;
    axi_r_t    r;
    logic      r_valid;
    logic      r_ready;
    axi_addr_t aw;
    logic      aw_valid;
    logic      aw_ready;
    axi_w_t    w;
    logic      w_valid;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;
    word_t     shadow [MEM_WORDS];  // expected memory image
    axi_addr_t last_ar;
    axi_addr_t last_aw;
    int        aw_count = 0;
    int        cycle_cnt = 0;

    dcache_top #(.INDEX_W(INDEX_W)) dut0 (.*);

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) mem0 (.*);

    always #20 clk = ~clk;

    function automatic word_t init_word(input logic [ADDR_W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    function automatic int widx(input logic [ADDR_W-1:0] a);
        return int'(a[MEM_IDX_W+1:2]);
    endfunction

    // word 1 of a line in set 3
    function automatic logic [ADDR_W-1:0] set3_addr(input int tag);
        return ADDR_W'((tag << (INDEX_W + OFFSET_W)) | (3 << OFFSET_W) | 4);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("ERR t=%0t %s got=%h/%0d/%0d exp=%h/%0d/%0d", $time, name,
                                got.addr, got.len, got.size, exp.addr, exp.len, exp.size));
    endtask

    // one request, held until req_ready; a hit sees ready one cycle later
    task automatic access(input logic [ADDR_W-1:0] addr, input strb_t wen, input word_t wdata,
                          input bit hit_exp, output word_t data);
        int lat;
        @(posedge clk);
        #(DRV_NS);
        req_valid = 1'b1;
        req       = '{addr: addr, wen: wen, wdata: wdata};
        lat       = 0;
        @(negedge clk);
        while (req_ready !== 1'b1) begin
            @(negedge clk);
            lat++;
        end
        data = rdata;
        @(posedge clk);
        #(DRV_NS);
        req_valid = 1'b0;
        req       = '0;
        if ((lat == 1) != hit_exp)
            abort_run($sformatf("access to %h: hit expected %0b but it took %0d cycles",
                                addr, hit_exp, lat));
        for (int b = 0; b < 4; b++) begin
            if (wen[b])
                shadow[widx(addr)][b*8 +: 8] = wdata[b*8 +: 8];
        end
    endtask

    task automatic load_check(input logic [ADDR_W-1:0] addr, input bit hit_exp);
        word_t data;
        access(addr, '0, '0, hit_exp, data);
        check_word($sformatf("rdata[%h]", addr), data, shadow[widx(addr)]);
    endtask

    task automatic store(input logic [ADDR_W-1:0] addr, input strb_t wen, input word_t wdata,
                         input bit hit_exp);
        word_t unused;
        access(addr, wen, wdata, hit_exp, unused);
    endtask

    task automatic test_cold_load();
        load_check(COLD_ADDR, 1'b0);
        check_addr("ar", last_ar,
                   '{addr: COLD_ADDR & ~32'h1f, len: 4'd7, size: AXI_SIZE_WORD});
    endtask

    task automatic test_hit_load();
        load_check(COLD_ADDR, 1'b1);
    endtask

    task automatic test_store_hit();
        store(COLD_ADDR, 4'b0101, 32'haabb_ccdd, 1'b1);
        load_check(COLD_ADDR, 1'b1);
    endtask

    task automatic test_store_miss();
        store(ALLOC_LINE + 8, 4'b1100, 32'h1234_5678, 1'b0);
        for (int k = 0; k < LINE_WORDS; k++)
            load_check(ALLOC_LINE + 4 * k, 1'b1);
    endtask

    // refills of tags 1..4 land in ways 0,2,1,3; touching tags 3,1,4,2
    // leaves bit 0 clear and bit 1 set, so way 1 (tag 3) is the victim
    task automatic test_plru_evict();
        int                n;
        logic [ADDR_W-1:0] base;
        for (int t = 1; t <= 4; t++)
            store(set3_addr(t), 4'hf, 32'h5e70_0000 + t, 1'b0);
        load_check(set3_addr(3), 1'b1);
        load_check(set3_addr(1), 1'b1);
        load_check(set3_addr(4), 1'b1);
        load_check(set3_addr(2), 1'b1);
        n    = aw_count;
        base = set3_addr(3) & ~32'h1f;
        store(set3_addr(5), 4'b0011, 32'h0000_beef, 1'b0);
        if (aw_count != n + 1)
            abort_run($sformatf("expected one write-back burst, saw %0d", aw_count - n));
        check_addr("aw", last_aw, '{addr: base, len: 4'd7, size: AXI_SIZE_WORD});
        for (int k = 0; k < LINE_WORDS; k++)
            check_word($sformatf("mem[%h]", base + 4 * k), mem0.mem[widx(base) + k],
                       shadow[widx(base) + k]);
    endtask

    task automatic test_reload_evicted();
        load_check(set3_addr(3), 1'b0);
        load_check(set3_addr(3) - 4, 1'b1);  // word 0, now a hit
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run("timeout: the tests did not finish within the cycle limit");
    end

    always @(negedge clk) begin
        if (ar_valid && ar_ready)
            last_ar = ar;
        if (aw_valid && aw_ready) begin
            last_aw = aw;
            aw_count++;
        end
        if (dut0.u_axi.sva0.fail_cnt != 0)
            abort_run("an AXI handshake assertion on the bus master failed");
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem0.mem[i] = init_word(ADDR_W'(i) << 2);
            shadow[i]   = init_word(ADDR_W'(i) << 2);
        end
        repeat (16) @(posedge clk);
        #(DRV_NS);
        rst = 1'b0;
        @(negedge clk);
        if (req_ready || ar_valid || aw_valid || w_valid || r_ready || b_ready)
            abort_run("a ready or valid output is high right after reset");
        test_cold_load();
        test_hit_load();
        test_store_hit();
        test_store_miss();
        test_plru_evict();
        test_reload_evicted();
        repeat (4) @(posedge clk);
        if (dut0.u_axi.sva0.fail_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

`default_nettype wire

/* testbench/dcache_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_sva (
    input wire                        clk,
    input wire                        rst,
    input wire dcache_pkg::axi_addr_t ar,
    input wire                        ar_valid,
    input wire                        ar_ready,
    input wire dcache_pkg::axi_addr_t aw,
    input wire                        aw_valid,
    input wire                        aw_ready,
    input wire dcache_pkg::axi_w_t    w,
    input wire                        w_valid,
    input wire                        w_ready
);
    logic [2:0]  beat_cnt;      // W beats taken in the current burst
    int unsigned fail_cnt = 0;

    always @(posedge clk) begin
        if (rst)
            beat_cnt <= '0;
        else if (w_valid && w_ready)
            beat_cnt <= beat_cnt + 1'b1;
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            $error("AR valid or payload changed before ready");
            fail_cnt++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            $error("AW valid or payload changed before ready");
            fail_cnt++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            $error("W valid or payload changed before ready");
            fail_cnt++;
        end

    // last only on the eighth beat
    w_last: assert property (@(posedge clk) disable iff (rst)
        w_valid |-> (w.last == (beat_cnt == 3'd7)))
        else begin
            $error("W last does not match the beat count");
            fail_cnt++;
        end

endmodule

bind dcache_axi_master dcache_sva sva0 (.*);

`default_nettype wire

/* testbench/axi_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model #(
    parameter int MEM_WORDS = 4096
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire dcache_pkg::axi_addr_t ar,
    input  wire                        ar_valid,
    output logic                       ar_ready,
    output dcache_pkg::axi_r_t         r,
    output logic                       r_valid,
    input  wire                        r_ready,
    input  wire dcache_pkg::axi_addr_t aw,
    input  wire                        aw_valid,
    output logic                       aw_ready,
    input  wire dcache_pkg::axi_w_t    w,
    input  wire                        w_valid,
    output logic                       w_ready,
    output logic                       b_valid,
    input  wire                        b_ready
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];  // preloaded by the testbench
    integer           seed = 32'h8dd9;
    logic [31:0]      stall;            // one draw per cycle, a bit per channel
    logic             rd_act;
    logic             wr_act;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [2:0]       rd_cnt;

    initial begin
        ar_ready = 1'b0;
        r        = '0;
        r_valid  = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            rd_act   <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            wr_act   <= 1'b0;
        end else begin
            stall = $random(seed);
            // read burst
            if (ar_valid && ar_ready) begin
                rd_act   <= 1'b1;
                rd_idx   <= ar.addr[IDX_W+1:2];
                rd_cnt   <= '0;
                ar_ready <= 1'b0;
            end else begin
                ar_ready <= !rd_act && stall[0];
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_idx  <= rd_idx + 1'b1;
                rd_cnt  <= rd_cnt + 1'b1;
                if (r.last)
                    rd_act <= 1'b0;
            end else if (rd_act && !r_valid && stall[1]) begin
                r_valid <= 1'b1;
                r       <= '{data: mem[rd_idx], last: (rd_cnt == 3'd7)};
            end
            // write burst
            if (aw_valid && aw_ready) begin
                wr_act   <= 1'b1;
                wr_idx   <= aw.addr[IDX_W+1:2];
                aw_ready <= 1'b0;
            end else begin
                aw_ready <= !wr_act && stall[2];
            end
            if (w_valid && w_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w.strb[b])
                        mem[wr_idx][b*8 +: 8] <= w.data[b*8 +: 8];
                end
                wr_idx  <= wr_idx + 1'b1;
                w_ready <= 1'b0;
                if (w.last)
                    b_valid <= 1'b1;
            end else begin
                w_ready <= wr_act && !b_valid && stall[3];
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                wr_act  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_W = 7
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req_valid,
    input  wire dcache_pkg::cpu_req_t req,
    output logic                      req_ready,
    output dcache_pkg::word_t         rdata,
    output dcache_pkg::axi_addr_t     ar,
    output logic                      ar_valid,
    input  wire                       ar_ready,
    input  wire dcache_pkg::axi_r_t   r,
    input  wire                       r_valid,
    output logic                      r_ready,
    output dcache_pkg::axi_addr_t     aw,
    output logic                      aw_valid,
    input  wire                       aw_ready,
    output dcache_pkg::axi_w_t        w,
    output logic                      w_valid,
    input  wire                       w_ready,
    input  wire                       b_valid,
    output logic                      b_ready
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // controller to tag store
    logic [INDEX_W-1:0]    index;
    logic [TAG_W-1:0]      cmp_tag;
    logic                  tag_we;
    logic [WAY_W-1:0]      tag_way;
    logic                  dirty_we;
    logic [WAY_W-1:0]      dirty_way;
    logic                  dirty_val;
    logic                  lru_we;
    logic [WAY_W-1:0]      lru_way;
    logic                  hit;
    logic [WAY_W-1:0]      hit_way;
    logic [WAY_W-1:0]      victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;

    // data store
    strb_t [WAYS-1:0][LINE_WORDS-1:0] wr_strb;
    word_t                            wr_data;
    word_t [WAYS-1:0][LINE_WORDS-1:0] lines;

    // bus master
    logic                  rf_start;
    logic [ADDR_W-1:0]     rf_addr;
    logic                  wb_start;
    logic [ADDR_W-1:0]     wb_addr;
    word_t [LINE_WORDS-1:0] wb_line;
    logic                  beat_valid;
    logic [WORD_SEL_W-1:0] beat_word;
    word_t                 beat_data;
    logic                  rf_done;
    logic                  wb_done;

    dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (.*);

    dcache_tag_store #(.INDEX_W(INDEX_W)) u_tags (.rd_index(index), .*);

    dcache_data_store #(.INDEX_W(INDEX_W)) u_data (.rd_index(index), .wr_index(index), .*);

    dcache_axi_master u_axi (.*);

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req_valid,
    input  wire dcache_pkg::cpu_req_t          req,
    output logic                               req_ready,
    output dcache_pkg::word_t                  rdata,
    output logic [INDEX_W-1:0]                 index,
    output logic [TAG_W-1:0]                   cmp_tag,
    output logic                               tag_we,
    output logic [dcache_pkg::WAY_W-1:0]       tag_way,
    output logic                               dirty_we,
    output logic [dcache_pkg::WAY_W-1:0]       dirty_way,
    output logic                               dirty_val,
    output logic                               lru_we,
    output logic [dcache_pkg::WAY_W-1:0]       lru_way,
    input  wire                                hit,
    input  wire [dcache_pkg::WAY_W-1:0]        hit_way,
    input  wire [dcache_pkg::WAY_W-1:0]        victim_way,
    input  wire                                victim_dirty,
    input  wire [TAG_W-1:0]                    victim_tag,
    output dcache_pkg::strb_t [dcache_pkg::WAYS-1:0][dcache_pkg::LINE_WORDS-1:0] wr_strb,
    output dcache_pkg::word_t                  wr_data,
    input  wire dcache_pkg::word_t [dcache_pkg::WAYS-1:0][dcache_pkg::LINE_WORDS-1:0] lines,
    output logic                               rf_start,
    output logic [dcache_pkg::ADDR_W-1:0]      rf_addr,
    output logic                               wb_start,
    output logic [dcache_pkg::ADDR_W-1:0]      wb_addr,
    output dcache_pkg::word_t [dcache_pkg::LINE_WORDS-1:0] wb_line,
    input  wire                                beat_valid,
    input  wire [dcache_pkg::WORD_SEL_W-1:0]   beat_word,
    input  wire dcache_pkg::word_t             beat_data,
    input  wire                                rf_done,
    input  wire                                wb_done
);
    import dcache_pkg::*;

    cache_state_t          state;
    cache_state_t          state_nxt;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  is_store;
    logic                  lookup_hit;
    logic                  lookup_miss;
    logic                  refill_end;
    logic                  own_beat;    // refill beat carrying the requested word
    word_t                 byte_mask;
    word_t                 merged;
    word_t                 rf_word_q;

    assign word_sel    = req.addr[OFFSET_W-1:2];
    assign index       = req.addr[OFFSET_W +: INDEX_W];
    assign cmp_tag     = req.addr[ADDR_W-1 -: TAG_W];
    assign is_store    = |req.wen;
    assign lookup_hit  = (state == LOOKUP) && hit;
    assign lookup_miss = (state == LOOKUP) && !hit;
    assign refill_end  = (state == REFILL) && rf_done;
    assign own_beat    = beat_valid && (beat_word == word_sel);

    always_comb begin
        for (int b = 0; b < WORD_W / 8; b++)
            byte_mask[b*8 +: 8] = {8{req.wen[b]}};
    end
    assign merged = (beat_data & ~byte_mask) | (req.wdata & byte_mask);

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (req_valid) state_nxt = LOOKUP;  // arrays read this cycle
            LOOKUP:    state_nxt = hit ? IDLE : (victim_dirty ? WRITEBACK : REFILL);
            WRITEBACK: if (wb_done) state_nxt = REFILL;
            REFILL:    if (rf_done) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    // bus requests, dirty victim goes out before the refill
    assign wb_start = lookup_miss && victim_dirty;
    assign rf_start = (lookup_miss && !victim_dirty) || ((state == WRITEBACK) && wb_done);
    assign rf_addr  = {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_addr  = {victim_tag, index, {OFFSET_W{1'b0}}};
    assign wb_line  = lines[victim_way];

    // tag, dirty and lru updates
    assign tag_we    = refill_end;
    assign tag_way   = victim_way;
    assign dirty_we  = (lookup_hit && is_store) || refill_end;
    assign dirty_way = lookup_hit ? hit_way : victim_way;
    assign dirty_val = is_store;    // load refill leaves the line clean
    assign lru_we    = lookup_hit || refill_end;
    assign lru_way   = lookup_hit ? hit_way : victim_way;

    always_comb begin
        wr_strb = '0;
        wr_data = beat_data;
        if (lookup_hit && is_store) begin
            wr_strb[hit_way][word_sel] = req.wen;
            wr_data = req.wdata;
        end else if ((state == REFILL) && beat_valid) begin
            wr_strb[victim_way][beat_word] = '1;
            if (own_beat && is_store)
                wr_data = merged;   // store bytes folded into the refill beat
        end
    end

    always_ff @(posedge clk) begin
        if (own_beat)
            rf_word_q <= beat_data;
    end

    always_comb begin
        if (state == REFILL)
            rdata = own_beat ? beat_data : rf_word_q;  // word may be the last beat
        else
            rdata = lines[hit_way][word_sel];
    end

    assign req_ready = lookup_hit || refill_end;

endmodule

`default_nettype wire

/* hdl/dcache_axi_master.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_axi_master (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                rf_start,
    input  wire [dcache_pkg::ADDR_W-1:0]       rf_addr,
    input  wire                                wb_start,
    input  wire [dcache_pkg::ADDR_W-1:0]       wb_addr,
    input  wire dcache_pkg::word_t [dcache_pkg::LINE_WORDS-1:0] wb_line,
    output logic                               beat_valid,
    output logic [dcache_pkg::WORD_SEL_W-1:0]  beat_word,
    output dcache_pkg::word_t                  beat_data,
    output logic                               rf_done,
    output logic                               wb_done,
    output dcache_pkg::axi_addr_t              ar,
    output logic                               ar_valid,
    input  wire                                ar_ready,
    input  wire dcache_pkg::axi_r_t            r,
    input  wire                                r_valid,
    output logic                               r_ready,
    output dcache_pkg::axi_addr_t              aw,
    output logic                               aw_valid,
    input  wire                                aw_ready,
    output dcache_pkg::axi_w_t                 w,
    output logic                               w_valid,
    input  wire                                w_ready,
    input  wire                                b_valid,
    output logic                               b_ready
);
    import dcache_pkg::*;

    logic                  rd_busy;
    logic                  ar_done;     // AR accepted, R beats pending
    logic                  wr_busy;
    logic                  aw_done;
    logic                  w_done;      // last W beat accepted, waiting on B
    logic [WORD_SEL_W-1:0] rcnt;
    logic [WORD_SEL_W-1:0] wcnt;
    logic [ADDR_W-1:0]     rf_addr_q;
    logic [ADDR_W-1:0]     wb_addr_q;
    logic                  w_fire;

    // read burst
    assign ar_valid   = rd_busy && !ar_done;
    assign r_ready    = rd_busy && ar_done;
    assign beat_valid = r_valid && r_ready;
    assign beat_word  = rcnt;
    assign beat_data  = r.data;
    assign rf_done    = beat_valid && r.last;
    assign ar         = '{addr: rf_addr_q, len: 4'(LINE_WORDS - 1), size: AXI_SIZE_WORD};

    // write burst, W starts once AW is taken
    assign aw_valid = wr_busy && !aw_done;
    assign w_valid  = aw_done && !w_done;
    assign b_ready  = w_done;
    assign w_fire   = w_valid && w_ready;
    assign wb_done  = b_valid && b_ready;
    assign aw       = '{addr: wb_addr_q, len: 4'(LINE_WORDS - 1), size: AXI_SIZE_WORD};
    assign w        = '{data: wb_line[wcnt], strb: '1, last: (wcnt == WORD_SEL_W'(LINE_WORDS - 1))};

    always_ff @(posedge clk) begin
        if (rf_start)
            rf_addr_q <= rf_addr;
        if (wb_start)
            wb_addr_q <= wb_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            ar_done <= 1'b0;
            rcnt    <= '0;
        end else begin
            if (rf_start)
                rd_busy <= 1'b1;
            else if (rf_done)
                rd_busy <= 1'b0;
            if (ar_valid && ar_ready)
                ar_done <= 1'b1;
            else if (rf_done)
                ar_done <= 1'b0;
            if (rf_done)
                rcnt <= '0;
            else if (beat_valid)
                rcnt <= rcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_busy <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            wcnt    <= '0;
        end else begin
            if (wb_start)
                wr_busy <= 1'b1;
            else if (wb_done)
                wr_busy <= 1'b0;
            if (aw_valid && aw_ready)
                aw_done <= 1'b1;
            else if (wb_done)
                aw_done <= 1'b0;
            if (w_fire && w.last)
                w_done <= 1'b1;
            else if (wb_done)
                w_done <= 1'b0;
            if (w_fire)
                wcnt <= wcnt + 1'b1;  // wraps to zero after the eighth beat
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_data_store.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_data_store #(
    parameter int INDEX_W = 7
) (
    input  wire                     clk,
    input  wire [INDEX_W-1:0]       rd_index,
    input  wire [INDEX_W-1:0]       wr_index,
    input  wire dcache_pkg::strb_t [dcache_pkg::WAYS-1:0][dcache_pkg::LINE_WORDS-1:0] wr_strb,
    input  wire dcache_pkg::word_t  wr_data,
    output dcache_pkg::word_t [dcache_pkg::WAYS-1:0][dcache_pkg::LINE_WORDS-1:0] lines
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << INDEX_W;
    localparam int BYTES = WORD_W / 8;

    // one word-wide bank per way and word position
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar i = 0; i < LINE_WORDS; i++) begin : g_bank
            word_t mem [SETS];
            word_t rd_q;

            always_ff @(posedge clk) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (wr_strb[w][i][b])
                        mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
                rd_q <= mem[rd_index];  // old data on a same-cycle write
            end

            assign lines[w][i] = rd_q;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_store #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [INDEX_W-1:0]            rd_index,
    input  wire [TAG_W-1:0]              cmp_tag,
    input  wire                          tag_we,
    input  wire [dcache_pkg::WAY_W-1:0]  tag_way,
    input  wire                          dirty_we,
    input  wire [dcache_pkg::WAY_W-1:0]  dirty_way,
    input  wire                          dirty_val,
    input  wire                          lru_we,
    input  wire [dcache_pkg::WAY_W-1:0]  lru_way,
    output logic                         hit,
    output logic [dcache_pkg::WAY_W-1:0] hit_way,
    output logic [dcache_pkg::WAY_W-1:0] victim_way,
    output logic                         victim_dirty,
    output logic [TAG_W-1:0]             victim_tag
);
    import dcache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [WAYS-1:0]    valid_r [SETS];
    logic [WAYS-1:0]    dirty_r [SETS];
    logic [WAYS-2:0]    lru_r   [SETS];
    logic [INDEX_W-1:0] idx_q;          // set seen by the compare, also the write set
    logic [TAG_W-1:0]   way_tag [WAYS];
    logic [WAYS-1:0]    way_hit;
    logic [WAYS-2:0]    lru_cur;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_W-1:0] mem [SETS];
        logic [TAG_W-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (tag_we && tag_way == w)
                mem[idx_q] <= cmp_tag;  // new line always carries the request tag
            rd_q <= mem[rd_index];
        end

        assign way_tag[w] = rd_q;
        assign way_hit[w] = valid_r[idx_q][w] && (rd_q == cmp_tag);
    end

    always_ff @(posedge clk) begin
        idx_q <= rd_index;
    end

    assign hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit[w])
                hit_way = WAY_W'(w);
        end
    end

    // bit 0 picks the pair, bit 1 or 2 the way inside it
    assign lru_cur      = lru_r[idx_q];
    assign victim_way   = {lru_cur[0], lru_cur[0] ? lru_cur[2] : lru_cur[1]};
    assign victim_dirty = valid_r[idx_q][victim_way] && dirty_r[idx_q][victim_way];
    assign victim_tag   = way_tag[victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
                lru_r[s]   <= '0;
            end
        end else begin
            if (tag_we)
                valid_r[idx_q][tag_way] <= 1'b1;
            if (dirty_we)
                dirty_r[idx_q][dirty_way] <= dirty_val;
            if (lru_we) begin
                lru_r[idx_q][0] <= ~lru_way[1];     // point at the other pair
                if (lru_way[1])
                    lru_r[idx_q][2] <= ~lru_way[0];
                else
                    lru_r[idx_q][1] <= ~lru_way[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int WAYS       = 4;  // tied to the 3-bit plru tree
    localparam int WAY_W      = 2;
    localparam int LINE_WORDS = 8;
    localparam int WORD_SEL_W = 3;
    localparam int OFFSET_W   = 5;  // byte offset inside a line

    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;  // 4-byte beats

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] strb_t;

    // processor request, a zero wen means load
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        strb_t             wen;
        word_t             wdata;
    } cpu_req_t;

    // address channel, same layout for AR and AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
    } axi_addr_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } cache_state_t;

endpackage

`default_nettype wire
